// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run with Verilator, pass only when the pass line is printed
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f sources.f \
        --top-module tcp_rx_tile_tb -o tcp_rx_tile_sim \
    && ./obj_dir/tcp_rx_tile_sim +verilator+error+limit+1000 \
        | tee /dev/stderr | grep -qx "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== source/noc_resp_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_resp_merger (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   reply_val
    ,input  tcp_rx_pkg::flit_t      reply_data

    ,input  logic                   app_new_flow_val
    ,input  tcp_rx_pkg::flow_id_t   app_new_flow_flowid

    ,output logic                   noc_out_val
    ,output tcp_rx_pkg::flit_t      noc_out_data
);
    import tcp_rx_pkg::*;

    // notification queue keeps flow ids, flit built on the way out
    flow_id_t                   notif_q [NOTIF_Q_DEPTH];
    logic [NOTIF_Q_IDX_W:0]     wr_ptr_q;
    logic [NOTIF_Q_IDX_W:0]     rd_ptr_q;

    logic                       q_empty;
    logic                       q_full;
    logic                       q_push;
    logic                       q_pop;
    flit_t                      notif_flit;

    assign q_empty = (wr_ptr_q == rd_ptr_q);
    assign q_full  = (wr_ptr_q[NOTIF_Q_IDX_W] != rd_ptr_q[NOTIF_Q_IDX_W])
                  && (wr_ptr_q[NOTIF_Q_IDX_W-1:0] == rd_ptr_q[NOTIF_Q_IDX_W-1:0]);

    // full queue drops the notification
    assign q_push = app_new_flow_val && !q_full;
    // reply has fixed priority
    assign q_pop  = !reply_val && !q_empty;

    assign notif_flit = build_ctrl_flit(NOTIF_FBITS, notif_q[rd_ptr_q[NOTIF_Q_IDX_W-1:0]], '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            noc_out_val <= 1'b0;
        end else begin
            if (q_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (q_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            noc_out_val <= reply_val || q_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            notif_q[wr_ptr_q[NOTIF_Q_IDX_W-1:0]] <= app_new_flow_flowid;
        end
        noc_out_data <= reply_val ? reply_data : notif_flit;
    end

endmodule

`default_nettype wire

// ==== source/rx_flit_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_flit_decode (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   noc_in_val
    ,input  tcp_rx_pkg::flit_t      noc_in_data

    ,output logic                   pkt_val
    ,output tcp_rx_pkg::flit_t      pkt_data
    ,output logic                   pkt_last

    ,output logic                   ptr_req_val
    ,output tcp_rx_pkg::flit_t      ptr_req_data
);
    import tcp_rx_pkg::*;

    dec_state_t     state_q;
    fbits_t         fbits_q;
    msg_len_t       remain_q;
    flit_t          body_q;

    fbits_t         in_fbits;
    msg_len_t       in_len;
    logic           body_val;

    assign in_fbits = noc_in_data[FBITS_HI:FBITS_LO];
    assign in_len   = noc_in_data[MSG_LEN_HI:MSG_LEN_LO];
    assign body_val = noc_in_val && (state_q == DEC_BODY);

    // message boundary tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= DEC_HDR;
            fbits_q  <= '0;
            remain_q <= '0;
        end else if (noc_in_val) begin
            if (state_q == DEC_HDR) begin
                fbits_q  <= in_fbits;
                remain_q <= in_len;
                // zero-length message has no body
                if (in_len != '0) begin
                    state_q <= DEC_BODY;
                end
            end else begin
                remain_q <= remain_q - 8'd1;
                if (remain_q == 8'd1) begin
                    state_q <= DEC_HDR;
                end
            end
        end
    end

    // steer body flits, unknown fbits fall through
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_val     <= 1'b0;
            pkt_last    <= 1'b0;
            ptr_req_val <= 1'b0;
        end else begin
            pkt_val     <= body_val && (fbits_q == PKT_IF_FBITS);
            pkt_last    <= body_val && (remain_q == 8'd1);
            ptr_req_val <= body_val && (fbits_q == PTR_IF_FBITS);
        end
    end

    always_ff @(posedge clk) begin
        body_q <= noc_in_data;
    end

    assign pkt_data     = body_q;
    assign ptr_req_data = body_q;

endmodule

`default_nettype wire

// ==== source/rx_ptr_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_ptr_table (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   ptr_req_val
    ,input  tcp_rx_pkg::flit_t      ptr_req_data

    ,input  logic                   app_new_flow_val
    ,input  tcp_rx_pkg::flow_id_t   app_new_flow_flowid

    ,output logic                   reply_val
    ,output tcp_rx_pkg::flit_t      reply_data
);
    import tcp_rx_pkg::*;

    rx_ptr_t        head_ptr_q [NUM_FLOWS];

    logic [1:0]     req_op;
    flow_id_t       req_flow;
    rx_ptr_t        req_ptr;
    logic           wr_en;
    logic           rd_en;

    assign req_op   = ptr_req_data[OPCODE_HI:OPCODE_LO];
    assign req_flow = ptr_req_data[FLOW_HI:FLOW_LO];
    assign req_ptr  = ptr_req_data[PTR_HI:PTR_LO];
    assign wr_en    = ptr_req_val && (req_op == PTR_OP_WR_HEAD);
    assign rd_en    = ptr_req_val && (req_op == PTR_OP_RD_HEAD);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_FLOWS; i++) begin
                head_ptr_q[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                head_ptr_q[req_flow] <= req_ptr;
            end
            // new flow clear overrides a same-flow write
            if (app_new_flow_val) begin
                head_ptr_q[app_new_flow_flowid] <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reply_val <= 1'b0;
        end else begin
            reply_val <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        reply_data <= build_ctrl_flit(PTR_REPLY_FBITS, req_flow, head_ptr_q[req_flow]);
    end

endmodule

`default_nettype wire

// ==== source/tcp_hdr_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_hdr_extract (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   pkt_val
    ,input  tcp_rx_pkg::flit_t      pkt_data
    ,input  logic                   pkt_last

    ,output logic                   hdr_val
    ,output tcp_rx_pkg::ip_addr_t   src_ip
    ,output tcp_rx_pkg::ip_addr_t   dst_ip
    ,output tcp_rx_pkg::tot_len_t   tcp_tot_len

    ,output logic                   data_val
    ,output tcp_rx_pkg::flit_t      data
    ,output logic                   data_last
);
    import tcp_rx_pkg::*;

    ext_state_t     state_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= EXT_IPS;
            hdr_val   <= 1'b0;
            data_val  <= 1'b0;
            data_last <= 1'b0;
        end else begin
            hdr_val   <= pkt_val && (state_q == EXT_LEN);
            data_val  <= pkt_val && (state_q == EXT_DATA);
            data_last <= pkt_val && (state_q == EXT_DATA) && pkt_last;
            if (pkt_val) begin
                case (state_q)
                    EXT_IPS:  state_q <= pkt_last ? EXT_IPS : EXT_LEN;
                    EXT_LEN:  state_q <= pkt_last ? EXT_IPS : EXT_DATA;
                    default:  state_q <= pkt_last ? EXT_IPS : EXT_DATA;
                endcase
            end
        end
    end

    // ip pair from body flit 0, held through the header strobe
    always_ff @(posedge clk) begin
        if (pkt_val && (state_q == EXT_IPS)) begin
            src_ip <= pkt_data[63:32];
            dst_ip <= pkt_data[31:0];
        end
        if (pkt_val && (state_q == EXT_LEN)) begin
            tcp_tot_len <= pkt_data[15:0];
        end
        if (pkt_val && (state_q == EXT_DATA)) begin
            data <= pkt_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/tcp_rx_pkg.sv ====
`default_nettype none

package tcp_rx_pkg;

    localparam int FLIT_W = 64;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [3:0]        fbits_t;
    typedef logic [7:0]        msg_len_t;
    typedef logic [31:0]       ip_addr_t;
    typedef logic [15:0]       tot_len_t;
    typedef logic [3:0]        flow_id_t;
    // payload pointer plus wrap bit
    typedef logic [16:0]       rx_ptr_t;

    localparam int NUM_FLOWS = 16;

    localparam fbits_t PKT_IF_FBITS    = 4'd1;
    localparam fbits_t PTR_IF_FBITS    = 4'd2;
    localparam fbits_t PTR_REPLY_FBITS = 4'd3;
    localparam fbits_t NOTIF_FBITS     = 4'd4;

    // header flit fields
    localparam int FBITS_HI   = 63;
    localparam int FBITS_LO   = 60;
    localparam int MSG_LEN_HI = 59;
    localparam int MSG_LEN_LO = 52;
    localparam int FLOW_HI    = 51;
    localparam int FLOW_LO    = 48;
    localparam int PTR_HI     = 16;
    localparam int PTR_LO     = 0;

    // pointer request body flit
    localparam int OPCODE_HI = 63;
    localparam int OPCODE_LO = 62;

    localparam logic [1:0] PTR_OP_WR_HEAD = 2'd0;
    localparam logic [1:0] PTR_OP_RD_HEAD = 2'd1;

    localparam int NOTIF_Q_DEPTH = 4;
    localparam int NOTIF_Q_IDX_W = $clog2(NOTIF_Q_DEPTH);

    typedef enum logic {
        DEC_HDR,
        DEC_BODY
    } dec_state_t;

    typedef enum logic [1:0] {
        EXT_IPS,
        EXT_LEN,
        EXT_DATA
    } ext_state_t;

    // single-flit control message, length field left at 0
    function automatic flit_t build_ctrl_flit(input fbits_t fbits, input flow_id_t flow,
                                              input rx_ptr_t ptr);
        flit_t flit;
        flit = '0;
        flit[FBITS_HI:FBITS_LO] = fbits;
        flit[FLOW_HI:FLOW_LO] = flow;
        flit[PTR_HI:PTR_LO] = ptr;
        return flit;
    endfunction

endpackage

`default_nettype wire

// ==== source/tcp_rx_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_tile (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   noc_in_val
    ,input  tcp_rx_pkg::flit_t      noc_in_data

    ,input  logic                   app_new_flow_val
    ,input  tcp_rx_pkg::flow_id_t   app_new_flow_flowid

    ,output logic                   noc_out_val
    ,output tcp_rx_pkg::flit_t      noc_out_data

    ,output logic                   hdr_val
    ,output tcp_rx_pkg::ip_addr_t   src_ip
    ,output tcp_rx_pkg::ip_addr_t   dst_ip
    ,output tcp_rx_pkg::tot_len_t   tcp_tot_len

    ,output logic                   data_val
    ,output tcp_rx_pkg::flit_t      data
    ,output logic                   data_last
);
    import tcp_rx_pkg::*;

    logic       pkt_val;
    flit_t      pkt_data;
    logic       pkt_last;

    logic       ptr_req_val;
    flit_t      ptr_req_data;

    logic       reply_val;
    flit_t      reply_data;

    rx_flit_decode decode (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.noc_in_val    (noc_in_val     )
        ,.noc_in_data   (noc_in_data    )
        ,.pkt_val       (pkt_val        )
        ,.pkt_data      (pkt_data       )
        ,.pkt_last      (pkt_last       )
        ,.ptr_req_val   (ptr_req_val    )
        ,.ptr_req_data  (ptr_req_data   )
    );

    tcp_hdr_extract hdr_extract (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.pkt_val       (pkt_val        )
        ,.pkt_data      (pkt_data       )
        ,.pkt_last      (pkt_last       )
        ,.hdr_val       (hdr_val        )
        ,.src_ip        (src_ip         )
        ,.dst_ip        (dst_ip         )
        ,.tcp_tot_len   (tcp_tot_len    )
        ,.data_val      (data_val       )
        ,.data          (data           )
        ,.data_last     (data_last      )
    );

    rx_ptr_table ptr_table (
         .clk                   (clk                    )
        ,.arst_n                (arst_n                 )
        ,.ptr_req_val           (ptr_req_val            )
        ,.ptr_req_data          (ptr_req_data           )
        ,.app_new_flow_val      (app_new_flow_val       )
        ,.app_new_flow_flowid   (app_new_flow_flowid    )
        ,.reply_val             (reply_val              )
        ,.reply_data            (reply_data             )
    );

    noc_resp_merger merger (
         .clk                   (clk                    )
        ,.arst_n                (arst_n                 )
        ,.reply_val             (reply_val              )
        ,.reply_data            (reply_data             )
        ,.app_new_flow_val      (app_new_flow_val       )
        ,.app_new_flow_flowid   (app_new_flow_flowid    )
        ,.noc_out_val           (noc_out_val            )
        ,.noc_out_data          (noc_out_data           )
    );

endmodule

`default_nettype wire

// ==== sources.f ====
source/tcp_rx_pkg.sv
source/rx_flit_decode.sv
source/tcp_hdr_extract.sv
source/rx_ptr_table.sv
source/noc_resp_merger.sv
source/tcp_rx_tile.sv
verif/tb_clk_gen.sv
verif/tcp_rx_tile_chk.sv
verif/tcp_rx_tile_tb.sv

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
     output logic   clk
);
    // 40 ns period
    localparam time HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verif/tcp_rx_tile_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_tile_chk (
     input  logic                   clk
    ,input  logic                   arst_n
    ,input  logic                   ptr_req_val
    ,input  tcp_rx_pkg::flit_t      ptr_req_data
    ,input  logic                   noc_out_val
    ,input  logic                   hdr_val
    ,input  logic                   data_val
);
    import tcp_rx_pkg::*;

    int unsigned fail_count = 0;

    a_strobes_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({noc_out_val, hdr_val, data_val}))
        else begin
            fail_count++;
            $error("output strobe is unknown after reset");
        end

    a_hdr_data_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(hdr_val && data_val))
        else begin
            fail_count++;
            $error("hdr_val and data_val high in the same cycle");
        end

    // request reaches the table one cycle after noc_in, so 2 more cycles to noc_out
    a_read_reply: assert property (@(posedge clk) disable iff (!arst_n)
        (ptr_req_val && (ptr_req_data[OPCODE_HI:OPCODE_LO] == PTR_OP_RD_HEAD))
        |-> ##2 noc_out_val)
        else begin
            fail_count++;
            $error("read-head request not answered 3 cycles after its body flit");
        end

endmodule

`default_nettype wire

// ==== verif/tcp_rx_tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_tile_tb;
    import tcp_rx_pkg::*;

    localparam int  CLK_PERIOD   = 40;
    localparam int  RESET_CYCLES = 16;
    localparam int  NUM_TESTS    = 6;
    localparam int  TEST_CYCLES  = 200;
    localparam int  WAIT_LIMIT   = 100;
    localparam time DRIVE_DLY    = 2;

    logic       clk;
    logic       arst_n;
    logic       noc_in_val;
    flit_t      noc_in_data;
    logic       app_new_flow_val;
    flow_id_t   app_new_flow_flowid;
    logic       noc_out_val;
    flit_t      noc_out_data;
    logic       hdr_val;
    ip_addr_t   src_ip;
    ip_addr_t   dst_ip;
    tot_len_t   tcp_tot_len;
    logic       data_val;
    flit_t      data;
    logic       data_last;

    logic [31:0]    lfsr_state = 32'he2cb0e3a;
    int             err_count = 0;
    int             tests_run = 0;
    int             tests_failed = 0;

    // header entries are {src, dst, len}, data entries {last, word}
    logic [79:0]    hdr_seen [$];
    logic [64:0]    data_seen [$];
    flit_t          out_seen [$];
    logic [79:0]    hdr_exp [$];
    logic [64:0]    data_exp [$];
    flit_t          out_exp [$];
    rx_ptr_t        ptr_model [NUM_FLOWS];

    tb_clk_gen clk_gen (
         .clk   (clk)
    );

    tcp_rx_tile dut_i (
         .clk                   (clk                    )
        ,.arst_n                (arst_n                 )
        ,.noc_in_val            (noc_in_val             )
        ,.noc_in_data           (noc_in_data            )
        ,.app_new_flow_val      (app_new_flow_val       )
        ,.app_new_flow_flowid   (app_new_flow_flowid    )
        ,.noc_out_val           (noc_out_val            )
        ,.noc_out_data          (noc_out_data           )
        ,.hdr_val               (hdr_val                )
        ,.src_ip                (src_ip                 )
        ,.dst_ip                (dst_ip                 )
        ,.tcp_tot_len           (tcp_tot_len            )
        ,.data_val              (data_val               )
        ,.data                  (data                   )
        ,.data_last             (data_last              )
    );

    bind tcp_rx_tile tcp_rx_tile_chk chk_i (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.ptr_req_val   (ptr_req_val    )
        ,.ptr_req_data  (ptr_req_data   )
        ,.noc_out_val   (noc_out_val    )
        ,.hdr_val       (hdr_val        )
        ,.data_val      (data_val       )
    );

    // galois lfsr, one step per bit
    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic flit_t msg_hdr(input fbits_t fbits, input msg_len_t len);
        flit_t f;
        f = '0;
        f[FBITS_HI:FBITS_LO] = fbits;
        f[MSG_LEN_HI:MSG_LEN_LO] = len;
        return f;
    endfunction

    function automatic flit_t req_flit(input logic [1:0] op, input flow_id_t flow,
                                       input rx_ptr_t ptr);
        flit_t f;
        f = '0;
        f[63:62] = op;
        f[51:48] = flow;
        f[16:0] = ptr;
        return f;
    endfunction

    // reply or notification as seen on noc_out
    function automatic flit_t expected_ctrl(input fbits_t fbits, input flow_id_t flow,
                                            input rx_ptr_t ptr);
        flit_t f;
        f = '0;
        f[63:60] = fbits;
        f[51:48] = flow;
        f[16:0] = ptr;
        return f;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic send_flit(input flit_t f);
        noc_in_val = 1'b1;
        noc_in_data = f;
        @(posedge clk);
        #DRIVE_DLY;
        noc_in_val = 1'b0;
        noc_in_data = '0;
    endtask

    task automatic new_flow(input flow_id_t flow);
        app_new_flow_val = 1'b1;
        app_new_flow_flowid = flow;
        ptr_model[flow] = '0;
        @(posedge clk);
        #DRIVE_DLY;
        app_new_flow_val = 1'b0;
    endtask

    task automatic write_head(input flow_id_t flow, input rx_ptr_t ptr);
        send_flit(msg_hdr(PTR_IF_FBITS, 8'd1));
        send_flit(req_flit(PTR_OP_WR_HEAD, flow, ptr));
        ptr_model[flow] = ptr;
    endtask

    task automatic read_head(input flow_id_t flow);
        send_flit(msg_hdr(PTR_IF_FBITS, 8'd1));
        send_flit(req_flit(PTR_OP_RD_HEAD, flow, '0));
        out_exp.push_back(expected_ctrl(PTR_REPLY_FBITS, flow, ptr_model[flow]));
    endtask

    task automatic send_packet(input int n_payload);
        ip_addr_t   src;
        ip_addr_t   dst;
        tot_len_t   tot_len;
        flit_t      word;
        src = ip_addr_t'(rand_bits(32));
        dst = ip_addr_t'(rand_bits(32));
        tot_len = tot_len_t'(rand_bits(16));
        send_flit(msg_hdr(PKT_IF_FBITS, msg_len_t'(n_payload + 2)));
        send_flit({src, dst});
        word = rand_bits(64);
        word[15:0] = tot_len;
        send_flit(word);
        hdr_exp.push_back({src, dst, tot_len});
        for (int i = 0; i < n_payload; i++) begin
            word = rand_bits(64);
            send_flit(word);
            data_exp.push_back({i == n_payload - 1, word});
        end
    endtask

    task automatic expect_eq(input logic [79:0] got, input logic [79:0] exp, input string what);
        assert (got === exp) else begin
            err_count++;
            $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_count(input int got, input int exp, input string what);
        assert (got == exp) else begin
            err_count++;
            $display("CHECK FAILED t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // wait until every expected item arrived, then a few cycles for strays
    task automatic wait_outputs();
        int n;
        n = 0;
        while ((hdr_seen.size() < hdr_exp.size() || data_seen.size() < data_exp.size()
                || out_seen.size() < out_exp.size()) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n == WAIT_LIMIT) begin
            err_count++;
            $display("timed out after %0d cycles waiting for DUT outputs", WAIT_LIMIT);
        end
        idle(4);
    endtask

    task automatic compare_all();
        expect_count(hdr_seen.size(), hdr_exp.size(), "header count");
        expect_count(data_seen.size(), data_exp.size(), "payload beat count");
        expect_count(out_seen.size(), out_exp.size(), "noc_out flit count");
        foreach (hdr_exp[i]) begin
            if (i < hdr_seen.size()) begin
                expect_eq(hdr_seen[i], hdr_exp[i], $sformatf("header %0d", i));
            end
        end
        foreach (data_exp[i]) begin
            if (i < data_seen.size()) begin
                expect_eq(80'(data_seen[i]), 80'(data_exp[i]), $sformatf("payload beat %0d", i));
            end
        end
        foreach (out_exp[i]) begin
            if (i < out_seen.size()) begin
                expect_eq(80'(out_seen[i]), 80'(out_exp[i]), $sformatf("noc_out flit %0d", i));
            end
        end
        hdr_seen.delete();
        data_seen.delete();
        out_seen.delete();
        hdr_exp.delete();
        data_exp.delete();
        out_exp.delete();
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (err_count == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_count - err_before);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (hdr_val) begin
                hdr_seen.push_back({src_ip, dst_ip, tcp_tot_len});
            end
            if (data_val) begin
                data_seen.push_back({data_last, data});
            end
            if (noc_out_val) begin
                out_seen.push_back(noc_out_data);
            end
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int e;
        int total;
        arst_n = 1'b0;
        noc_in_val = 1'b0;
        noc_in_data = '0;
        app_new_flow_val = 1'b0;
        app_new_flow_flowid = '0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            ptr_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        idle(1);

        e = err_count;
        send_packet(3);
        wait_outputs();
        compare_all();
        end_test("packet header", e);

        // second packet has no payload
        e = err_count;
        send_packet(4);
        send_packet(0);
        wait_outputs();
        compare_all();
        end_test("payload beats", e);

        e = err_count;
        read_head(4'd5);
        write_head(4'd9, rx_ptr_t'(rand_bits(17)) | 17'd1);
        read_head(4'd9);
        wait_outputs();
        compare_all();
        end_test("head pointer read and write", e);

        e = err_count;
        write_head(4'd7, rx_ptr_t'(rand_bits(17)) | 17'd1);
        new_flow(4'd7);
        out_exp.push_back(expected_ctrl(NOTIF_FBITS, 4'd7, '0));
        wait_outputs();
        read_head(4'd7);
        wait_outputs();
        compare_all();
        end_test("new flow notification", e);

        e = err_count;
        send_flit(msg_hdr(4'hb, 8'd3));
        for (int i = 0; i < 3; i++) begin
            send_flit(rand_bits(64));
        end
        send_packet(1);
        wait_outputs();
        compare_all();
        end_test("unknown fbits dropped", e);

        // notification meets the reply at the merger
        e = err_count;
        read_head(4'd9);
        idle(1);
        new_flow(4'd12);
        out_exp.push_back(expected_ctrl(NOTIF_FBITS, 4'd12, '0));
        wait_outputs();
        for (int i = 0; i < 5; i++) begin
            out_exp.push_back(expected_ctrl(PTR_REPLY_FBITS, flow_id_t'(i), ptr_model[i]));
        end
        for (int i = 0; i < 4; i++) begin
            out_exp.push_back(expected_ctrl(NOTIF_FBITS, flow_id_t'(10 + i), '0));
        end
        fork
            begin
                send_flit(msg_hdr(PTR_IF_FBITS, 8'd5));
                for (int i = 0; i < 5; i++) begin
                    send_flit(req_flit(PTR_OP_RD_HEAD, flow_id_t'(i), '0));
                end
            end
            begin
                idle(3);
                for (int i = 0; i < 5; i++) begin
                    new_flow(flow_id_t'(10 + i));
                end
            end
        join
        wait_outputs();
        compare_all();
        end_test("merger priority and queue", e);

        total = err_count + int'(dut_i.chk_i.fail_count);
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count, dut_i.chk_i.fail_count);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
